// File: sys_board_glue.f
hw/board_pkg.sv
hw/bus_cycle_if.sv
hw/io_decode.sv
hw/mem_decode.sv
hw/dma_hold_arb.sv
hw/nmi_ctrl.sv
hw/sys_board_glue.sv
bench/sys_board_glue_sva.sv
bench/sys_board_glue_tb.sv

// File: bench/sys_board_glue_tb.sv
// Testbench for the system board glue logic
// Random and directed I/O, memory, refresh, DMA hold and NMI cycles;
// every output is compared with reference models on each clock
module sys_board_glue_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import board_pkg::*;

   localparam logic [3:0] ROM_SEG = 4'hF;
   localparam int MEM_W = ROM_CHIPS + 2 * RAM_BANKS;
   localparam int TIMEOUT_CYCLES = 3000;   // Tests take about 870 cycles

   logic                 clk;
   logic                 reset_n;
   logic [ADDR_W-1:0]    addr_i;
   logic                 ior_i, iow_i, memr_i, memw_i, dack0_i;
   logic [DATA_W-1:0]    data_i, mem_data_i;
   logic                 hrq_i, lock_n_i;
   logic [2:0]           status_n_i;
   logic                 io_ch_ck_n_i, io_ck_en_i, mem_par_i, par_chk_en_i;
   logic                 np_int_i, np_instl_i;
   io_sel_e              io_sel_o;
   logic                 wr_dma_page_o, holda_o, aen_o, dma_aen_o;
   logic [ROM_CHIPS-1:0] rom_cs_n_o;
   logic [RAM_BANKS-1:0] ras_n_o, cas_n_o;
   logic                 par_err_o, io_ch_ck_o, nmi_o;

   // Expected outputs stepped each clock by the compare process
   string          test_name   = "reset";
   string          exp_name    = "reset";
   io_sel_e        exp_io_sel  = IO_NONE;
   logic           exp_wr_page = 1'b0;
   logic           exp_wr_mask = 1'b0;
   logic [MEM_W:0] exp_mem     = {1'b0, {MEM_W{1'b1}}};   // RAM read flag on top
   arb_state_e     exp_arb     = ARB_CPU;
   logic [3:0]     exp_nmi     = '0;                      // Mask, parity, check, 8087

   sys_board_glue #(.ROM_SEG(ROM_SEG)) sys_board_glue_i (.*);

   function automatic io_sel_e ref_io_sel(input logic [ADDR_W-1:0] a, input logic aen);
      if (aen)
         return IO_NONE;
      case (a[9:0] >> 5)   // 32 ports per group from 0x000
         10'd0:   return IO_DMA;
         10'd1:   return IO_PIC;
         10'd2:   return IO_PIT;
         10'd3:   return IO_PPI;
         10'd4:   return IO_DMA_PAGE;
         10'd5:   return IO_NMI_MASK;
         default: return IO_NONE;
      endcase
   endfunction

   function automatic logic [MEM_W:0] ref_mem(input logic [ADDR_W-1:0] a, input logic rd,
         input logic wr, input logic dack0, input logic aen);
      logic [ROM_CHIPS-1:0] rom;
      logic [RAM_BANKS-1:0] ras;
      logic [RAM_BANKS-1:0] cas;
      logic                 ram_rd;
      rom    = '1;
      ras    = '1;
      cas    = '1;
      ram_rd = 1'b0;
      if (rd && dack0) begin
         ras = '0;   // Refresh
      end else begin
         if (rd && !aen && a[19:16] == ROM_SEG)
            rom[a[15:13]] = 1'b0;
         if (a < 20'h40000 && (rd || wr)) begin
            ras[a[17:16]] = 1'b0;
            cas[a[17:16]] = 1'b0;
         end
         ram_rd = rd && (a < 20'h40000);
      end
      return {ram_rd, rom, ras, cas};
   endfunction

   function automatic arb_state_e ref_arb(input arb_state_e st, input logic hrq,
         input logic [2:0] status_n, input logic lock_n);
      if (!hrq)
         return ARB_CPU;
      case (st)
         ARB_CPU: return (status_n == 3'b111 && lock_n) ? ARB_REQ : ARB_CPU;
         ARB_REQ: return ARB_HOLD;
         default: return ARB_DMA;
      endcase
   endfunction

   function automatic logic [3:0] ref_nmi(input logic [3:0] st, input logic wr_mask,
         input logic ram_rd, input logic [DATA_W-1:0] data, input logic ck_n,
         input logic ck_en, input logic [DATA_W-1:0] mdata, input logic mpar,
         input logic par_en, input logic np_int, input logic np_instl);
      logic mask;
      logic par;
      logic chk;
      mask = wr_mask ? data[7] : st[3];
      par  = par_en && (st[2] || (ram_rd && ($countones({mpar, mdata}) % 2 == 0)));
      chk  = ck_en && (st[1] || !ck_n);
      return {mask, par, chk, np_int && np_instl};
   endfunction

   // Failures seen so far by both bound checkers
   function automatic int assert_failures();
      return sys_board_glue_i.dma_hold_arb_i.arb_sva_i.fail_cnt
             + sys_board_glue_i.io_decode_i.io_sva_i.fail_cnt;
   endfunction

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_io_sel(input string name, input io_sel_e exp, input io_sel_e act);
      if (exp !== act) begin
         $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
         abort_run();
      end
   endtask

   task automatic check_vec(input string name, input logic [MEM_W-1:0] exp,
         input logic [MEM_W-1:0] act);
      if (exp !== act) begin
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic io_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      @(posedge clk);
      addr_i <= a;
      data_i <= d;   // Held for the mask load a clock later
      iow_i  <= 1'b1;
      @(posedge clk);
      iow_i  <= 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, stimulus never finished", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   // Outputs are read mid-cycle and the inputs seen here are sampled at the next edge
   initial begin : compare
      logic aen;
      wait (reset_n === 1'b1);
      forever begin
         @(negedge clk);
         if (assert_failures() != 0) begin
            $display("bound assertion failed during %s", exp_name);
            abort_run();
         end
         check_io_sel({exp_name, " io_sel"}, exp_io_sel, io_sel_o);
         check_bit({exp_name, " wr_dma_page"}, exp_wr_page, wr_dma_page_o);
         check_vec({exp_name, " rom/ras/cas"}, exp_mem[MEM_W-1:0],
                   {rom_cs_n_o, ras_n_o, cas_n_o});
         check_bit({exp_name, " holda"}, exp_arb inside {ARB_HOLD, ARB_DMA}, holda_o);
         check_bit({exp_name, " aen"}, exp_arb inside {ARB_HOLD, ARB_DMA}, aen_o);
         check_bit({exp_name, " dma_aen"}, exp_arb == ARB_DMA, dma_aen_o);
         check_bit({exp_name, " par_err"}, exp_nmi[2], par_err_o);
         check_bit({exp_name, " io_ch_ck"}, exp_nmi[1], io_ch_ck_o);
         check_bit({exp_name, " nmi"}, exp_nmi[3] && (|exp_nmi[2:0]), nmi_o);
         aen         = exp_arb inside {ARB_HOLD, ARB_DMA};
         exp_nmi     = ref_nmi(exp_nmi, exp_wr_mask, exp_mem[MEM_W], data_i, io_ch_ck_n_i,
                               io_ck_en_i, mem_data_i, mem_par_i, par_chk_en_i,
                               np_int_i, np_instl_i);
         exp_io_sel  = ref_io_sel(addr_i, aen);
         exp_wr_page = iow_i && (exp_io_sel == IO_DMA_PAGE);
         exp_wr_mask = iow_i && (exp_io_sel == IO_NMI_MASK);
         exp_mem     = ref_mem(addr_i, memr_i, memw_i, dack0_i, aen);
         exp_arb     = ref_arb(exp_arb, hrq_i, status_n_i, lock_n_i);
         exp_name    = test_name;
      end
   end

   initial begin : stimulus
      int         i;
      logic [1:0] op;
      void'($urandom(32'h29d9));
      reset_n = 1'b0;
      addr_i  = '0;
      {ior_i, iow_i, memr_i, memw_i, dack0_i} = '0;
      {data_i, mem_data_i, mem_par_i, par_chk_en_i} = '0;
      {hrq_i, io_ck_en_i, np_int_i, np_instl_i} = '0;
      {status_n_i, lock_n_i, io_ch_ck_n_i} = '1;
      repeat (8) @(posedge clk);
      reset_n <= 1'b1;

      test_name = "io_decode";
      for (i = 0; i < 200; i++) begin
         @(posedge clk);
         addr_i <= ADDR_W'($urandom) & (($urandom % 4 == 0) ? 20'h003FF : 20'h000FF);
         {ior_i, iow_i} <= 2'($urandom);
         data_i <= 8'($urandom);
         hrq_i  <= (i >= 100 && i < 150);   // DMA owns AEN for a while
      end
      io_write(20'h00081, 8'h00);   // Page register
      io_write(20'h000A0, 8'h80);   // NMI mask on

      test_name = "mem_decode";
      {ior_i, hrq_i} <= '0;
      for (i = 0; i < 300; i++) begin
         @(posedge clk);
         case ($urandom % 4)
            0, 1:    addr_i <= ADDR_W'($urandom) & 20'h3FFFF;   // RAM
            2:       addr_i <= {ROM_SEG, 16'($urandom)};
            default: addr_i <= ADDR_W'($urandom);
         endcase
         op = 2'($urandom % 3);
         memr_i <= (op == 2'd0);
         memw_i <= (op == 2'd1);
      end
      @(posedge clk);
      addr_i <= 20'h80000;   // Neither ROM nor RAM
      memr_i <= 1'b1;
      memw_i <= 1'b0;

      test_name = "refresh";
      for (i = 0; i < 40; i++) begin
         @(posedge clk);
         addr_i  <= ADDR_W'($urandom);
         memr_i  <= 1'b1;
         memw_i  <= 1'($urandom);
         dack0_i <= 1'b1;
      end

      test_name = "hold_arb";
      @(posedge clk);
      {memr_i, memw_i, dack0_i} <= '0;
      hrq_i      <= 1'b1;
      status_n_i <= 3'b100;   // CPU busy
      repeat (6) @(posedge clk);
      status_n_i <= 3'b111;
      lock_n_i   <= 1'b0;
      repeat (4) @(posedge clk);
      lock_n_i   <= 1'b1;
      repeat (6) @(posedge clk);
      hrq_i      <= 1'b0;
      repeat (3) @(posedge clk);
      for (i = 0; i < 120; i++) begin
         @(posedge clk);
         hrq_i      <= ($urandom % 8 != 0);
         status_n_i <= ($urandom % 2) ? 3'b111 : 3'($urandom);
         lock_n_i   <= ($urandom % 4 != 0);
         addr_i     <= ADDR_W'($urandom) & 20'hF03FF;
         {ior_i, iow_i, memr_i} <= 3'($urandom);
      end

      test_name = "nmi";
      @(posedge clk);
      {hrq_i, ior_i, iow_i, memr_i} <= '0;
      io_write(20'h000A0, 8'h00);   // Mask off
      io_ck_en_i   <= 1'b1;
      io_ch_ck_n_i <= 1'b0;
      @(posedge clk);
      io_ch_ck_n_i <= 1'b1;
      io_write(20'h000A0, 8'h80);
      @(posedge clk);
      io_ck_en_i   <= 1'b0;
      par_chk_en_i <= 1'b1;
      addr_i       <= 20'h01000;
      memr_i       <= 1'b1;   // Nine zero bits give even parity
      @(posedge clk);
      memr_i       <= 1'b0;
      repeat (2) @(posedge clk);
      par_chk_en_i <= 1'b0;
      np_instl_i   <= 1'b1;
      np_int_i     <= 1'b1;
      repeat (2) @(posedge clk);
      np_instl_i   <= 1'b0;
      for (i = 0; i < 150; i++) begin
         @(posedge clk);
         {io_ck_en_i, io_ch_ck_n_i, par_chk_en_i, np_int_i, np_instl_i} <= 5'($urandom);
         {memr_i, iow_i, mem_par_i} <= 3'($urandom);
         addr_i     <= ADDR_W'($urandom) & 20'h300FF;
         data_i     <= 8'($urandom);
         mem_data_i <= 8'($urandom);
      end
      @(posedge clk);
      {memr_i, iow_i} <= '0;
      repeat (4) @(posedge clk);
      if (assert_failures() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("bound assertions failed during the run");
         abort_run();
      end
   end

endmodule

// File: bench/sys_board_glue_sva.sv
// Bound checker for the DMA hold arbiter and the I/O port decoder
// One instance sits in each block; the side a block lacks is tied
// to values that keep its rules quiet
module sys_board_glue_sva (
   input logic                  clk,
   input logic                  reset_n,
   input logic                  hrq_i,
   input logic                  holda_o,
   input logic                  dma_aen_o,
   input board_pkg::arb_state_e state_q,
   input board_pkg::io_sel_e    io_sel_o
);
   timeunit 1ns;
   timeprecision 100ps;

   import board_pkg::*;

   int fail_cnt = 0;   // Failed assertions so far

   // 8237 drives addresses only while the CPU is held, from a clock after hold acknowledge
   dma_aen_needs_holda : assert property (@(posedge clk) disable iff (!reset_n)
      dma_aen_o |-> holda_o && $past(holda_o))
      else begin
         fail_cnt++;
         $error("DMA address enable active without an earlier hold acknowledge");
      end

   release_to_cpu : assert property (@(posedge clk) disable iff (!reset_n)
      !hrq_i |=> state_q == ARB_CPU)
      else begin
         fail_cnt++;
         $error("arbiter kept the bus after the hold request dropped");
      end

   // Reset leaves no port group selected
   idle_after_reset : assert property (@(posedge clk) !reset_n |=> io_sel_o == IO_NONE)
      else begin
         fail_cnt++;
         $error("port select active right after reset");
      end

endmodule

bind dma_hold_arb sys_board_glue_sva arb_sva_i (
   .clk       (clk),
   .reset_n   (reset_n),
   .hrq_i     (hrq_i),
   .holda_o   (holda_o),
   .dma_aen_o (dma_aen_o),
   .state_q   (state_q),
   .io_sel_o  (board_pkg::IO_NONE)
);

bind io_decode sys_board_glue_sva io_sva_i (
   .clk       (clk),
   .reset_n   (reset_n),
   .hrq_i     (1'b1),
   .holda_o   (1'b0),
   .dma_aen_o (1'b0),
   .state_q   (board_pkg::ARB_CPU),
   .io_sel_o  (io_sel_o)
);

// File: hw/sys_board_glue.sv
// System board glue logic
// Port decoder, memory decoder with refresh, DMA hold arbiter and
// NMI controller of the 8088 system board. The bus cycle from the
// pins goes to both decoders over one interface, with the address
// enable taken from the arbiter.
module sys_board_glue #(
   parameter logic [3:0] ROM_SEG = 4'hF
) (
   input  logic                            clk,
   input  logic                            reset_n,
   // Bus cycle
   input  logic [board_pkg::ADDR_W-1:0]    addr_i,
   input  logic                            ior_i,
   input  logic                            iow_i,
   input  logic                            memr_i,
   input  logic                            memw_i,
   input  logic [board_pkg::DATA_W-1:0]    data_i,
   input  logic                            dack0_i,
   // Arbitration
   input  logic                            hrq_i,
   input  logic [2:0]                      status_n_i,
   input  logic                            lock_n_i,
   // NMI sources
   input  logic                            io_ch_ck_n_i,
   input  logic                            io_ck_en_i,
   input  logic [board_pkg::DATA_W-1:0]    mem_data_i,
   input  logic                            mem_par_i,
   input  logic                            par_chk_en_i,
   input  logic                            np_int_i,
   input  logic                            np_instl_i,
   // Decodes
   output board_pkg::io_sel_e              io_sel_o,
   output logic                            wr_dma_page_o,
   output logic [board_pkg::ROM_CHIPS-1:0] rom_cs_n_o,
   output logic [board_pkg::RAM_BANKS-1:0] ras_n_o,
   output logic [board_pkg::RAM_BANKS-1:0] cas_n_o,
   // Arbiter
   output logic                            holda_o,
   output logic                            aen_o,
   output logic                            dma_aen_o,
   // NMI
   output logic                            par_err_o,
   output logic                            io_ch_ck_o,
   output logic                            nmi_o
);

   logic wr_nmi_mask;   // Port decoder to mask register
   logic ram_rd;        // Memory decoder to parity check

   bus_cycle_if bus ();

   assign bus.addr = addr_i;
   assign bus.ior  = ior_i;
   assign bus.iow  = iow_i;
   assign bus.memr = memr_i;
   assign bus.memw = memw_i;
   assign bus.aen  = aen_o;   // Arbiter owns AEN

   io_decode io_decode_i (
      .clk           (clk),
      .reset_n       (reset_n),
      .bus           (bus.decoder),
      .io_sel_o      (io_sel_o),
      .wr_dma_page_o (wr_dma_page_o),
      .wr_nmi_mask_o (wr_nmi_mask)
   );

   mem_decode #(
      .ROM_SEG (ROM_SEG)
   ) mem_decode_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .bus        (bus.decoder),
      .dack0_i    (dack0_i),
      .rom_cs_n_o (rom_cs_n_o),
      .ras_n_o    (ras_n_o),
      .cas_n_o    (cas_n_o),
      .ram_rd_o   (ram_rd)
   );

   dma_hold_arb dma_hold_arb_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .hrq_i      (hrq_i),
      .status_n_i (status_n_i),
      .lock_n_i   (lock_n_i),
      .holda_o    (holda_o),
      .aen_o      (aen_o),
      .dma_aen_o  (dma_aen_o)
   );

   nmi_ctrl nmi_ctrl_i (
      .clk           (clk),
      .reset_n       (reset_n),
      .wr_nmi_mask_i (wr_nmi_mask),
      .data_i        (data_i),
      .io_ch_ck_n_i  (io_ch_ck_n_i),
      .io_ck_en_i    (io_ck_en_i),
      .ram_rd_i      (ram_rd),
      .mem_data_i    (mem_data_i),
      .mem_par_i     (mem_par_i),
      .par_chk_en_i  (par_chk_en_i),
      .np_int_i      (np_int_i),
      .np_instl_i    (np_instl_i),
      .par_err_o     (par_err_o),
      .io_ch_ck_o    (io_ch_ck_o),
      .nmi_o         (nmi_o)
   );

endmodule

// File: hw/nmi_ctrl.sv
// NMI controller
// NMI mask register written through port 0xA0, I/O channel check
// latch, RAM parity latch and the 8087 interrupt path. The latch
// outputs are readable as status through the PPI.
module nmi_ctrl (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         wr_nmi_mask_i,
   input  logic [board_pkg::DATA_W-1:0] data_i,
   input  logic                         io_ch_ck_n_i,   // From the slots
   input  logic                         io_ck_en_i,
   input  logic                         ram_rd_i,       // RAM read strobe
   input  logic [board_pkg::DATA_W-1:0] mem_data_i,
   input  logic                         mem_par_i,
   input  logic                         par_chk_en_i,
   input  logic                         np_int_i,       // 8087 INT
   input  logic                         np_instl_i,     // Coprocessor switch
   output logic                         par_err_o,
   output logic                         io_ch_ck_o,
   output logic                         nmi_o
);

   import board_pkg::*;

   logic mask_q;      // NMI enable, data bit 7
   logic par_q;
   logic chk_q;
   logic np_q;
   logic par_bad;

   // Odd parity is stored, so even parity over nine bits is an error
   assign par_bad = ~^{mem_par_i, mem_data_i};

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mask_q <= 1'b0;
         par_q  <= 1'b0;
         chk_q  <= 1'b0;
         np_q   <= 1'b0;
      end else begin
         if (wr_nmi_mask_i)
            mask_q <= data_i[DATA_W-1];

         // Channel check latch, held clear while disabled
         if (!io_ck_en_i)
            chk_q <= 1'b0;
         else if (!io_ch_ck_n_i)
            chk_q <= 1'b1;

         if (!par_chk_en_i)
            par_q <= 1'b0;
         else if (ram_rd_i && par_bad)
            par_q <= 1'b1;

         np_q <= np_int_i && np_instl_i;   // Ignored without an 8087
      end
   end

   assign par_err_o  = par_q;
   assign io_ch_ck_o = chk_q;
   assign nmi_o      = mask_q && (par_q || chk_q || np_q);

endmodule

// File: hw/dma_hold_arb.sv
// DMA hold arbiter
// Hands the system bus from the 8088 to the 8237. The request is
// only taken on a passive, unlocked CPU status; hold acknowledge
// follows one clock later and the DMA address drivers one clock
// after that. Dropping the request gives the bus back at once.
module dma_hold_arb (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       hrq_i,        // 8237 hold request
   input  logic [2:0] status_n_i,   // CPU S2..S0
   input  logic       lock_n_i,
   output logic       holda_o,
   output logic       aen_o,
   output logic       dma_aen_o
);

   import board_pkg::*;

   arb_state_e state_q;
   arb_state_e state_d;
   logic       bus_idle;

   // All status lines high is the passive state
   assign bus_idle = (&status_n_i) && lock_n_i;

   always_comb begin
      state_d = state_q;
      if (!hrq_i) begin
         state_d = ARB_CPU;   // Release from any state
      end else begin
         case (state_q)
            ARB_CPU:  if (bus_idle) state_d = ARB_REQ;
            ARB_REQ:  state_d = ARB_HOLD;
            ARB_HOLD: state_d = ARB_DMA;
            ARB_DMA:  state_d = ARB_DMA;
            default:  state_d = ARB_CPU;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state_q <= ARB_CPU;
      end else begin
         state_q <= state_d;
      end
   end

   // Hold acknowledge also floats the CPU side of the bus
   assign holda_o   = (state_q == ARB_HOLD) || (state_q == ARB_DMA);
   assign aen_o     = holda_o;
   assign dma_aen_o = (state_q == ARB_DMA);   // 8237 address drivers

endmodule

// File: hw/mem_decode.sv
// Memory decoder
// Registers the ROM socket selects in the ROM segment and the
// row and column strobes of the four RAM banks below 256 KB.
// A refresh cycle (DACK0 with MEMR) fires every RAS and no CAS.
// RAM reads are flagged for the parity checker.
module mem_decode #(
   parameter logic [3:0] ROM_SEG = 4'hF
) (
   input  logic                            clk,
   input  logic                            reset_n,
   bus_cycle_if.decoder                    bus,
   input  logic                            dack0_i,
   output logic [board_pkg::ROM_CHIPS-1:0] rom_cs_n_o,
   output logic [board_pkg::RAM_BANKS-1:0] ras_n_o,
   output logic [board_pkg::RAM_BANKS-1:0] cas_n_o,
   output logic                            ram_rd_o
);

   import board_pkg::*;

   localparam int ROM_IDX_W  = $clog2(ROM_CHIPS);
   localparam int BANK_IDX_W = $clog2(RAM_BANKS);

   logic                 rom_hit;
   logic                 ram_hit;
   logic                 ram_cmd;
   logic                 refresh;
   logic [ROM_CHIPS-1:0] rom_sel;    // One-hot socket
   logic [RAM_BANKS-1:0] bank_sel;   // One-hot bank

   // Top nibble picks the ROM segment, CPU reads only
   assign rom_hit = bus.memr && !bus.aen && (bus.addr[ADDR_W-1 -: 4] == ROM_SEG);

   // Everything above bit 17 zero means first 256 KB
   assign ram_hit = (bus.addr[ADDR_W-1:RAM_TOP_BIT] == '0);
   assign ram_cmd = bus.memr || bus.memw;

   // 8237 channel 0 refresh read
   assign refresh = bus.memr && dack0_i;

   assign rom_sel  = ROM_CHIPS'(1) << bus.addr[ROM_CS_LSB +: ROM_IDX_W];
   assign bank_sel = RAM_BANKS'(1) << bus.addr[BANK_LSB +: BANK_IDX_W];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rom_cs_n_o <= '1;
         ras_n_o    <= '1;
         cas_n_o    <= '1;
         ram_rd_o   <= 1'b0;
      end else if (refresh) begin
         // Row only refresh on all banks
         rom_cs_n_o <= '1;
         ras_n_o    <= '0;
         cas_n_o    <= '1;
         ram_rd_o   <= 1'b0;
      end else begin
         rom_cs_n_o <= rom_hit ? ~rom_sel : '1;
         if (ram_hit && ram_cmd) begin
            ras_n_o <= ~bank_sel;
            cas_n_o <= ~bank_sel;
         end else begin
            ras_n_o <= '1;
            cas_n_o <= '1;
         end
         ram_rd_o   <= ram_hit && bus.memr;   // Parity check qualifier
      end
   end

endmodule

// File: hw/io_decode.sv
// I/O port decoder
// Splits the lower I/O window into 32-port groups and registers
// the group select, plus write strobes for the DMA page
// registers and the NMI mask register
module io_decode (
   input  logic              clk,
   input  logic              reset_n,
   bus_cycle_if.decoder      bus,
   output board_pkg::io_sel_e io_sel_o,
   output logic              wr_dma_page_o,
   output logic              wr_nmi_mask_o
);

   import board_pkg::*;

   logic [2:0] grp;      // Address bits 7..5
   logic       in_win;   // Port inside 0x000..0x0FF, CPU cycle
   io_sel_e    sel_d;

   assign grp    = bus.addr[IO_GRP_LSB +: 3];
   assign in_win = (bus.addr[IO_WIN_MSB -: 2] == 2'b00) && !bus.aen;

   always_comb begin
      sel_d = IO_NONE;
      if (in_win) begin
         // Groups 6 and 7 have no device on the board
         case (grp)
            3'd0:    sel_d = IO_DMA;
            3'd1:    sel_d = IO_PIC;
            3'd2:    sel_d = IO_PIT;
            3'd3:    sel_d = IO_PPI;
            3'd4:    sel_d = IO_DMA_PAGE;
            3'd5:    sel_d = IO_NMI_MASK;
            default: sel_d = IO_NONE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         io_sel_o      <= IO_NONE;
         wr_dma_page_o <= 1'b0;
         wr_nmi_mask_o <= 1'b0;
      end else begin
         io_sel_o      <= sel_d;
         wr_dma_page_o <= (sel_d == IO_DMA_PAGE) && bus.iow;
         wr_nmi_mask_o <= (sel_d == IO_NMI_MASK) && bus.iow;
      end
   end

endmodule

// File: hw/bus_cycle_if.sv
// Bus cycle interface
// Address, command strobes and address enable of the current
// system bus cycle, fanned out to the port and memory decoders
interface bus_cycle_if;

   logic [board_pkg::ADDR_W-1:0] addr;
   logic ior;    // I/O read
   logic iow;    // I/O write
   logic memr;   // Memory read
   logic memw;   // Memory write
   logic aen;    // DMA owns the address bus

   // Decoders only look at the cycle
   modport decoder (
      input addr,
      input ior,
      input iow,
      input memr,
      input memw,
      input aen
   );

   // Top level drives it
   modport source (
      output addr,
      output ior,
      output iow,
      output memr,
      output memw,
      output aen
   );

endinterface

// File: hw/board_pkg.sv
// System board glue package
// Bus widths, board address map constants and the shared enums
// for the I/O port groups and the DMA hold arbiter states
package board_pkg;

   parameter int ADDR_W    = 20;   // 8088 address bus
   parameter int DATA_W    = 8;
   parameter int RAM_BANKS = 4;
   parameter int ROM_CHIPS = 8;

   // I/O map, 32 ports per group below 0x100
   parameter int IO_GRP_LSB = 5;
   parameter int IO_WIN_MSB = 9;    // Bits 9..8 must be zero

   // Memory map
   parameter int ROM_CS_LSB  = 13;  // 8 KB per ROM socket
   parameter int BANK_LSB    = 16;  // 64 KB per RAM bank
   parameter int RAM_TOP_BIT = 18;  // RAM ends at 256 KB

   // Decoded I/O port groups
   typedef enum logic [2:0] {
      IO_DMA      = 3'd0,   // 0x000 8237
      IO_PIC      = 3'd1,   // 0x020 8259
      IO_PIT      = 3'd2,   // 0x040 8253
      IO_PPI      = 3'd3,   // 0x060 8255
      IO_DMA_PAGE = 3'd4,   // 0x080 page registers
      IO_NMI_MASK = 3'd5,   // 0x0A0 NMI mask
      IO_NONE     = 3'd7
   } io_sel_e;

   // DMA hold arbiter states
   typedef enum logic [1:0] {
      ARB_CPU  = 2'd0,
      ARB_REQ  = 2'd1,
      ARB_HOLD = 2'd2,
      ARB_DMA  = 2'd3
   } arb_state_e;

endpackage
